// File: hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data word and pc width.
`define CORE_XLEN 32

`define CORE_REG_ADDR_W 5
`define CORE_REG_COUNT 32

// shifts use only the low bits of src2.
`define CORE_SHAMT_W 5

// trace write enable is one bit per byte of the word.
`define CORE_WEN_W 4

`endif

// File: hdl/core_pkg.sv
`default_nettype none
`include "core_defines.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]       word_t;
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`CORE_WEN_W-1:0]      wen_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        NOR  = 4'd4,
        XOR  = 4'd5,
        SLT  = 4'd6,
        SLTU = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9,
        SRA  = 4'd10
    } alu_op_t;

endpackage

`default_nettype wire

// File: hdl/regfile.sv
`default_nettype none
`include "core_defines.svh"

module regfile (
    input  wire                      clk,
    input  wire core_pkg::reg_addr_t i_raddr1,
    input  wire core_pkg::reg_addr_t i_raddr2,
    input  wire core_pkg::reg_addr_t i_raddr3,
    input  wire core_pkg::reg_addr_t i_raddr4,
    output core_pkg::word_t          o_rdata1,
    output core_pkg::word_t          o_rdata2,
    output core_pkg::word_t          o_rdata3,
    output core_pkg::word_t          o_rdata4,
    input  wire                      i_we1,
    input  wire core_pkg::reg_addr_t i_waddr1,
    input  wire core_pkg::word_t     i_wdata1,
    input  wire                      i_we2,
    input  wire core_pkg::reg_addr_t i_waddr2,
    input  wire core_pkg::word_t     i_wdata2
);

    core_pkg::word_t mem [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (i_we1 && i_waddr1 != '0)
            mem[i_waddr1] <= i_wdata1;
        if (i_we2 && i_waddr2 != '0)
            mem[i_waddr2] <= i_wdata2; // lane b is younger, so its write lands last.
    end

    // entry 0 is never written, so r0 is forced to zero on the read side.
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : mem[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : mem[i_raddr2];
    assign o_rdata3 = (i_raddr3 == '0) ? '0 : mem[i_raddr3];
    assign o_rdata4 = (i_raddr4 == '0) ? '0 : mem[i_raddr4];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none
`include "core_defines.svh"

module alu (
    input  wire core_pkg::alu_op_t i_op,
    input  wire core_pkg::word_t   i_src1,
    input  wire core_pkg::word_t   i_src2,
    output core_pkg::word_t        o_result
);

    logic [`CORE_SHAMT_W-1:0] shamt;

    assign shamt = i_src2[`CORE_SHAMT_W-1:0];

    always_comb begin
        case (i_op)
            core_pkg::ADD:  o_result = i_src1 + i_src2;
            core_pkg::SUB:  o_result = i_src1 - i_src2;
            core_pkg::AND:  o_result = i_src1 & i_src2;
            core_pkg::OR:   o_result = i_src1 | i_src2;
            core_pkg::NOR:  o_result = ~(i_src1 | i_src2);
            core_pkg::XOR:  o_result = i_src1 ^ i_src2;
            core_pkg::SLT:  o_result = core_pkg::word_t'($signed(i_src1) < $signed(i_src2));
            core_pkg::SLTU: o_result = core_pkg::word_t'(i_src1 < i_src2);
            core_pkg::SLL:  o_result = i_src1 << shamt;
            core_pkg::SRL:  o_result = i_src1 >> shamt;
            core_pkg::SRA:  o_result = $signed(i_src1) >>> shamt; // sign bit fills from the left.
            default:        o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/ro_stage.sv
`default_nettype none

module ro_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      i_a_valid,
    input  wire core_pkg::word_t     i_a_pc,
    input  wire core_pkg::alu_op_t   i_a_op,
    input  wire core_pkg::reg_addr_t i_a_src1,
    input  wire core_pkg::reg_addr_t i_a_src2,
    input  wire                      i_a_src2_is_imm,
    input  wire core_pkg::word_t     i_a_imm,
    input  wire core_pkg::reg_addr_t i_a_dest,
    input  wire                      i_b_valid,
    input  wire core_pkg::word_t     i_b_pc,
    input  wire core_pkg::alu_op_t   i_b_op,
    input  wire core_pkg::reg_addr_t i_b_src1,
    input  wire core_pkg::reg_addr_t i_b_src2,
    input  wire                      i_b_src2_is_imm,
    input  wire core_pkg::word_t     i_b_imm,
    input  wire core_pkg::reg_addr_t i_b_dest,
    output logic                     o_issue_ready,
    output core_pkg::reg_addr_t      o_raddr1,
    output core_pkg::reg_addr_t      o_raddr2,
    output core_pkg::reg_addr_t      o_raddr3,
    output core_pkg::reg_addr_t      o_raddr4,
    input  wire core_pkg::word_t     i_rdata1,
    input  wire core_pkg::word_t     i_rdata2,
    input  wire core_pkg::word_t     i_rdata3,
    input  wire core_pkg::word_t     i_rdata4,
    input  wire                      i_alu_a_wen,
    input  wire core_pkg::reg_addr_t i_alu_a_dest,
    input  wire core_pkg::word_t     i_alu_a_result,
    input  wire                      i_alu_b_wen,
    input  wire core_pkg::reg_addr_t i_alu_b_dest,
    input  wire core_pkg::word_t     i_alu_b_result,
    input  wire                      i_ex_a_wen,
    input  wire core_pkg::reg_addr_t i_ex_a_dest,
    input  wire core_pkg::word_t     i_ex_a_result,
    input  wire                      i_ex_b_wen,
    input  wire core_pkg::reg_addr_t i_ex_b_dest,
    input  wire core_pkg::word_t     i_ex_b_result,
    input  wire                      i_wb_a_we,
    input  wire core_pkg::reg_addr_t i_wb_a_waddr,
    input  wire core_pkg::word_t     i_wb_a_wdata,
    input  wire                      i_wb_b_we,
    input  wire core_pkg::reg_addr_t i_wb_b_waddr,
    input  wire core_pkg::word_t     i_wb_b_wdata,
    output logic                     o_ro_a_valid,
    output core_pkg::word_t          o_ro_a_pc,
    output core_pkg::alu_op_t        o_ro_a_op,
    output core_pkg::word_t          o_ro_a_src1,
    output core_pkg::word_t          o_ro_a_src2,
    output core_pkg::reg_addr_t      o_ro_a_dest,
    output logic                     o_ro_a_wen,
    output logic                     o_ro_b_valid,
    output core_pkg::word_t          o_ro_b_pc,
    output core_pkg::alu_op_t        o_ro_b_op,
    output core_pkg::word_t          o_ro_b_src1,
    output core_pkg::word_t          o_ro_b_src2,
    output core_pkg::reg_addr_t      o_ro_b_dest,
    output logic                     o_ro_b_wen
);

    logic                a_done; // lane a of the held pair went ahead alone last cycle.
    logic                b_reads_a;
    logic                split;
    logic                issue_a;
    logic                issue_b;
    core_pkg::reg_addr_t raddr [4];
    core_pkg::word_t     rdata [4];
    core_pkg::word_t     opnd [4];
    logic                fw_en [6];
    core_pkg::reg_addr_t fw_dest [6];
    core_pkg::word_t     fw_data [6];

    assign b_reads_a = i_a_valid && i_b_valid && i_a_dest != '0 &&
                       (i_b_src1 == i_a_dest || (!i_b_src2_is_imm && i_b_src2 == i_a_dest));
    assign split = b_reads_a && !a_done;
    assign o_issue_ready = !split;
    assign issue_a = i_a_valid && !a_done;
    assign issue_b = i_b_valid && !split;

    assign raddr = '{i_a_src1, i_a_src2, i_b_src1, i_b_src2};
    assign rdata = '{i_rdata1, i_rdata2, i_rdata3, i_rdata4};
    assign o_raddr1 = raddr[0];
    assign o_raddr2 = raddr[1];
    assign o_raddr3 = raddr[2];
    assign o_raddr4 = raddr[3];

    // index 0 is the youngest producer.
    assign fw_en = '{i_alu_b_wen, i_alu_a_wen, i_ex_b_wen, i_ex_a_wen, i_wb_b_we, i_wb_a_we};
    assign fw_dest = '{i_alu_b_dest, i_alu_a_dest, i_ex_b_dest, i_ex_a_dest,
                       i_wb_b_waddr, i_wb_a_waddr};
    assign fw_data = '{i_alu_b_result, i_alu_a_result, i_ex_b_result, i_ex_a_result,
                       i_wb_b_wdata, i_wb_a_wdata};

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            opnd[p] = rdata[p];
            for (int s = 5; s >= 0; s--) begin
                if (fw_en[s] && fw_dest[s] == raddr[p])
                    opnd[p] = fw_data[s]; // walking oldest to youngest leaves the youngest.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a_done       <= 1'b0;
            o_ro_a_valid <= 1'b0;
            o_ro_a_wen   <= 1'b0;
            o_ro_b_valid <= 1'b0;
            o_ro_b_wen   <= 1'b0;
        end else begin
            a_done       <= split;
            o_ro_a_valid <= issue_a;
            o_ro_a_wen   <= issue_a && i_a_dest != '0;
            o_ro_b_valid <= issue_b;
            o_ro_b_wen   <= issue_b && i_b_dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_a) begin
            o_ro_a_pc   <= i_a_pc;
            o_ro_a_op   <= i_a_op;
            o_ro_a_src1 <= opnd[0];
            o_ro_a_src2 <= i_a_src2_is_imm ? i_a_imm : opnd[1];
            o_ro_a_dest <= i_a_dest;
        end
        if (issue_b) begin
            o_ro_b_pc   <= i_b_pc;
            o_ro_b_op   <= i_b_op;
            o_ro_b_src1 <= opnd[2];
            o_ro_b_src2 <= i_b_src2_is_imm ? i_b_imm : opnd[3];
            o_ro_b_dest <= i_b_dest;
        end
    end

    // a pair that sits in the ro register together never had b reading a.
    assert property (@(posedge clk) disable iff (reset)
        o_ro_a_valid && o_ro_b_valid && o_ro_a_dest != '0 |->
            $past(i_b_src1) != o_ro_a_dest &&
            ($past(i_b_src2_is_imm) || $past(i_b_src2) != o_ro_a_dest));

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
`default_nettype none

module ex_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      i_ro_a_valid,
    input  wire core_pkg::word_t     i_ro_a_pc,
    input  wire core_pkg::alu_op_t   i_ro_a_op,
    input  wire core_pkg::word_t     i_ro_a_src1,
    input  wire core_pkg::word_t     i_ro_a_src2,
    input  wire core_pkg::reg_addr_t i_ro_a_dest,
    input  wire                      i_ro_a_wen,
    input  wire                      i_ro_b_valid,
    input  wire core_pkg::word_t     i_ro_b_pc,
    input  wire core_pkg::alu_op_t   i_ro_b_op,
    input  wire core_pkg::word_t     i_ro_b_src1,
    input  wire core_pkg::word_t     i_ro_b_src2,
    input  wire core_pkg::reg_addr_t i_ro_b_dest,
    input  wire                      i_ro_b_wen,
    output logic                     o_alu_a_wen,
    output core_pkg::reg_addr_t      o_alu_a_dest,
    output core_pkg::word_t          o_alu_a_result,
    output logic                     o_alu_b_wen,
    output core_pkg::reg_addr_t      o_alu_b_dest,
    output core_pkg::word_t          o_alu_b_result,
    output logic                     o_ex_a_valid,
    output core_pkg::word_t          o_ex_a_pc,
    output logic                     o_ex_a_wen,
    output core_pkg::reg_addr_t      o_ex_a_dest,
    output core_pkg::word_t          o_ex_a_result,
    output logic                     o_ex_b_valid,
    output core_pkg::word_t          o_ex_b_pc,
    output logic                     o_ex_b_wen,
    output core_pkg::reg_addr_t      o_ex_b_dest,
    output core_pkg::word_t          o_ex_b_result
);

    alu alu_a (.i_op(i_ro_a_op), .i_src1(i_ro_a_src1), .i_src2(i_ro_a_src2),
               .o_result(o_alu_a_result));
    alu alu_b (.i_op(i_ro_b_op), .i_src1(i_ro_b_src1), .i_src2(i_ro_b_src2),
               .o_result(o_alu_b_result));

    // results leave the ALUs in the same cycle, so ro can use them right away.
    assign o_alu_a_wen  = i_ro_a_wen;
    assign o_alu_a_dest = i_ro_a_dest;
    assign o_alu_b_wen  = i_ro_b_wen;
    assign o_alu_b_dest = i_ro_b_dest;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_ex_a_valid <= 1'b0;
            o_ex_a_wen   <= 1'b0;
            o_ex_b_valid <= 1'b0;
            o_ex_b_wen   <= 1'b0;
        end else begin
            o_ex_a_valid <= i_ro_a_valid;
            o_ex_a_wen   <= i_ro_a_wen;
            o_ex_b_valid <= i_ro_b_valid;
            o_ex_b_wen   <= i_ro_b_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ro_a_valid) begin
            o_ex_a_pc     <= i_ro_a_pc;
            o_ex_a_dest   <= i_ro_a_dest;
            o_ex_a_result <= o_alu_a_result;
        end
        if (i_ro_b_valid) begin
            o_ex_b_pc     <= i_ro_b_pc;
            o_ex_b_dest   <= i_ro_b_dest;
            o_ex_b_result <= o_alu_b_result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/wb_stage.sv
`default_nettype none
`include "core_defines.svh"

module wb_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      i_ex_a_valid,
    input  wire core_pkg::word_t     i_ex_a_pc,
    input  wire                      i_ex_a_wen,
    input  wire core_pkg::reg_addr_t i_ex_a_dest,
    input  wire core_pkg::word_t     i_ex_a_result,
    input  wire                      i_ex_b_valid,
    input  wire core_pkg::word_t     i_ex_b_pc,
    input  wire                      i_ex_b_wen,
    input  wire core_pkg::reg_addr_t i_ex_b_dest,
    input  wire core_pkg::word_t     i_ex_b_result,
    output logic                     o_wb_a_we,
    output core_pkg::reg_addr_t      o_wb_a_waddr,
    output core_pkg::word_t          o_wb_a_wdata,
    output logic                     o_wb_b_we,
    output core_pkg::reg_addr_t      o_wb_b_waddr,
    output core_pkg::word_t          o_wb_b_wdata,
    output core_pkg::word_t          o_debug0_wb_pc,
    output core_pkg::wen_t           o_debug0_wb_rf_wen,
    output core_pkg::reg_addr_t      o_debug0_wb_rf_wnum,
    output core_pkg::word_t          o_debug0_wb_rf_wdata,
    output core_pkg::word_t          o_debug1_wb_pc,
    output core_pkg::wen_t           o_debug1_wb_rf_wen,
    output core_pkg::reg_addr_t      o_debug1_wb_rf_wnum,
    output core_pkg::word_t          o_debug1_wb_rf_wdata
);

    core_pkg::word_t wb_a_pc;
    core_pkg::word_t wb_b_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_wb_a_we <= 1'b0;
            o_wb_b_we <= 1'b0;
        end else begin
            o_wb_a_we <= i_ex_a_wen;
            o_wb_b_we <= i_ex_b_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ex_a_valid) begin
            wb_a_pc      <= i_ex_a_pc;
            o_wb_a_waddr <= i_ex_a_dest;
            o_wb_a_wdata <= i_ex_a_result;
        end
        if (i_ex_b_valid) begin
            wb_b_pc      <= i_ex_b_pc;
            o_wb_b_waddr <= i_ex_b_dest;
            o_wb_b_wdata <= i_ex_b_result;
        end
    end

    assign o_debug0_wb_pc       = wb_a_pc;
    assign o_debug0_wb_rf_wen   = {`CORE_WEN_W{o_wb_a_we}};
    assign o_debug0_wb_rf_wnum  = o_wb_a_waddr;
    assign o_debug0_wb_rf_wdata = o_wb_a_wdata;
    assign o_debug1_wb_pc       = wb_b_pc;
    assign o_debug1_wb_rf_wen   = {`CORE_WEN_W{o_wb_b_we}};
    assign o_debug1_wb_rf_wnum  = o_wb_b_waddr;
    assign o_debug1_wb_rf_wdata = o_wb_b_wdata;

    // the wen raised back in ro must never reach the register file for r0.
    assert property (@(posedge clk) disable iff (reset)
        (o_wb_a_we |-> o_wb_a_waddr != '0) and (o_wb_b_we |-> o_wb_b_waddr != '0));

endmodule

`default_nettype wire

// File: hdl/dual_issue_core.sv
`default_nettype none

module dual_issue_core (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      i_a_valid,
    input  wire core_pkg::word_t     i_a_pc,
    input  wire core_pkg::alu_op_t   i_a_op,
    input  wire core_pkg::reg_addr_t i_a_src1,
    input  wire core_pkg::reg_addr_t i_a_src2,
    input  wire                      i_a_src2_is_imm,
    input  wire core_pkg::word_t     i_a_imm,
    input  wire core_pkg::reg_addr_t i_a_dest,
    input  wire                      i_b_valid,
    input  wire core_pkg::word_t     i_b_pc,
    input  wire core_pkg::alu_op_t   i_b_op,
    input  wire core_pkg::reg_addr_t i_b_src1,
    input  wire core_pkg::reg_addr_t i_b_src2,
    input  wire                      i_b_src2_is_imm,
    input  wire core_pkg::word_t     i_b_imm,
    input  wire core_pkg::reg_addr_t i_b_dest,
    output logic                     o_issue_ready,
    output core_pkg::word_t          o_debug0_wb_pc,
    output core_pkg::wen_t           o_debug0_wb_rf_wen,
    output core_pkg::reg_addr_t      o_debug0_wb_rf_wnum,
    output core_pkg::word_t          o_debug0_wb_rf_wdata,
    output core_pkg::word_t          o_debug1_wb_pc,
    output core_pkg::wen_t           o_debug1_wb_rf_wen,
    output core_pkg::reg_addr_t      o_debug1_wb_rf_wnum,
    output core_pkg::word_t          o_debug1_wb_rf_wdata
);

    core_pkg::reg_addr_t raddr1, raddr2, raddr3, raddr4;
    core_pkg::word_t     rdata1, rdata2, rdata3, rdata4;
    logic                ro_a_valid, ro_b_valid, ro_a_wen, ro_b_wen;
    core_pkg::word_t     ro_a_pc, ro_b_pc, ro_a_src1, ro_b_src1, ro_a_src2, ro_b_src2;
    core_pkg::alu_op_t   ro_a_op, ro_b_op;
    core_pkg::reg_addr_t ro_a_dest, ro_b_dest;
    logic                alu_a_wen, alu_b_wen, ex_a_valid, ex_b_valid, ex_a_wen, ex_b_wen;
    core_pkg::reg_addr_t alu_a_dest, alu_b_dest, ex_a_dest, ex_b_dest;
    core_pkg::word_t     alu_a_result, alu_b_result, ex_a_result, ex_b_result;
    core_pkg::word_t     ex_a_pc, ex_b_pc;
    logic                wb_a_we, wb_b_we;
    core_pkg::reg_addr_t wb_a_waddr, wb_b_waddr;
    core_pkg::word_t     wb_a_wdata, wb_b_wdata;

    ro_stage ro_stage0 (
        .clk, .reset, .o_issue_ready,
        .i_a_valid, .i_a_pc, .i_a_op, .i_a_src1, .i_a_src2,
        .i_a_src2_is_imm, .i_a_imm, .i_a_dest,
        .i_b_valid, .i_b_pc, .i_b_op, .i_b_src1, .i_b_src2,
        .i_b_src2_is_imm, .i_b_imm, .i_b_dest,
        .o_raddr1(raddr1), .o_raddr2(raddr2), .o_raddr3(raddr3), .o_raddr4(raddr4),
        .i_rdata1(rdata1), .i_rdata2(rdata2), .i_rdata3(rdata3), .i_rdata4(rdata4),
        .i_alu_a_wen(alu_a_wen), .i_alu_a_dest(alu_a_dest), .i_alu_a_result(alu_a_result),
        .i_alu_b_wen(alu_b_wen), .i_alu_b_dest(alu_b_dest), .i_alu_b_result(alu_b_result),
        .i_ex_a_wen(ex_a_wen), .i_ex_a_dest(ex_a_dest), .i_ex_a_result(ex_a_result),
        .i_ex_b_wen(ex_b_wen), .i_ex_b_dest(ex_b_dest), .i_ex_b_result(ex_b_result),
        .i_wb_a_we(wb_a_we), .i_wb_a_waddr(wb_a_waddr), .i_wb_a_wdata(wb_a_wdata),
        .i_wb_b_we(wb_b_we), .i_wb_b_waddr(wb_b_waddr), .i_wb_b_wdata(wb_b_wdata),
        .o_ro_a_valid(ro_a_valid), .o_ro_a_pc(ro_a_pc), .o_ro_a_op(ro_a_op),
        .o_ro_a_src1(ro_a_src1), .o_ro_a_src2(ro_a_src2), .o_ro_a_dest(ro_a_dest),
        .o_ro_a_wen(ro_a_wen),
        .o_ro_b_valid(ro_b_valid), .o_ro_b_pc(ro_b_pc), .o_ro_b_op(ro_b_op),
        .o_ro_b_src1(ro_b_src1), .o_ro_b_src2(ro_b_src2), .o_ro_b_dest(ro_b_dest),
        .o_ro_b_wen(ro_b_wen)
    );

    ex_stage ex_stage0 (
        .clk, .reset,
        .i_ro_a_valid(ro_a_valid), .i_ro_a_pc(ro_a_pc), .i_ro_a_op(ro_a_op),
        .i_ro_a_src1(ro_a_src1), .i_ro_a_src2(ro_a_src2), .i_ro_a_dest(ro_a_dest),
        .i_ro_a_wen(ro_a_wen),
        .i_ro_b_valid(ro_b_valid), .i_ro_b_pc(ro_b_pc), .i_ro_b_op(ro_b_op),
        .i_ro_b_src1(ro_b_src1), .i_ro_b_src2(ro_b_src2), .i_ro_b_dest(ro_b_dest),
        .i_ro_b_wen(ro_b_wen),
        .o_alu_a_wen(alu_a_wen), .o_alu_a_dest(alu_a_dest), .o_alu_a_result(alu_a_result),
        .o_alu_b_wen(alu_b_wen), .o_alu_b_dest(alu_b_dest), .o_alu_b_result(alu_b_result),
        .o_ex_a_valid(ex_a_valid), .o_ex_a_pc(ex_a_pc), .o_ex_a_wen(ex_a_wen),
        .o_ex_a_dest(ex_a_dest), .o_ex_a_result(ex_a_result),
        .o_ex_b_valid(ex_b_valid), .o_ex_b_pc(ex_b_pc), .o_ex_b_wen(ex_b_wen),
        .o_ex_b_dest(ex_b_dest), .o_ex_b_result(ex_b_result)
    );

    wb_stage wb_stage0 (
        .clk, .reset,
        .i_ex_a_valid(ex_a_valid), .i_ex_a_pc(ex_a_pc), .i_ex_a_wen(ex_a_wen),
        .i_ex_a_dest(ex_a_dest), .i_ex_a_result(ex_a_result),
        .i_ex_b_valid(ex_b_valid), .i_ex_b_pc(ex_b_pc), .i_ex_b_wen(ex_b_wen),
        .i_ex_b_dest(ex_b_dest), .i_ex_b_result(ex_b_result),
        .o_wb_a_we(wb_a_we), .o_wb_a_waddr(wb_a_waddr), .o_wb_a_wdata(wb_a_wdata),
        .o_wb_b_we(wb_b_we), .o_wb_b_waddr(wb_b_waddr), .o_wb_b_wdata(wb_b_wdata),
        .o_debug0_wb_pc, .o_debug0_wb_rf_wen, .o_debug0_wb_rf_wnum, .o_debug0_wb_rf_wdata,
        .o_debug1_wb_pc, .o_debug1_wb_rf_wen, .o_debug1_wb_rf_wnum, .o_debug1_wb_rf_wdata
    );

    regfile regfile0 (
        .clk,
        .i_raddr1(raddr1), .i_raddr2(raddr2), .i_raddr3(raddr3), .i_raddr4(raddr4),
        .o_rdata1(rdata1), .o_rdata2(rdata2), .o_rdata3(rdata3), .o_rdata4(rdata4),
        .i_we1(wb_a_we), .i_waddr1(wb_a_waddr), .i_wdata1(wb_a_wdata),
        .i_we2(wb_b_we), .i_waddr2(wb_b_waddr), .i_wdata2(wb_b_wdata)
    );

endmodule

`default_nettype wire

// File: verification/core_tb.sv
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                valid;
        core_pkg::word_t     pc;
        logic [3:0]          op;
        core_pkg::reg_addr_t src1;
        core_pkg::reg_addr_t src2;
        logic                is_imm;
        core_pkg::word_t     imm;
        core_pkg::reg_addr_t dest;
    } lane_t;

    typedef struct packed {
        core_pkg::word_t     pc;
        core_pkg::reg_addr_t wnum;
        core_pkg::word_t     wdata;
    } trace_t;

    logic                clk = 1'b0;
    logic                reset;
    logic                i_a_valid, i_b_valid;
    core_pkg::word_t     i_a_pc, i_b_pc, i_a_imm, i_b_imm;
    core_pkg::alu_op_t   i_a_op, i_b_op;
    core_pkg::reg_addr_t i_a_src1, i_a_src2, i_a_dest, i_b_src1, i_b_src2, i_b_dest;
    logic                i_a_src2_is_imm, i_b_src2_is_imm;
    logic                o_issue_ready;
    core_pkg::word_t     o_debug0_wb_pc, o_debug0_wb_rf_wdata;
    core_pkg::word_t     o_debug1_wb_pc, o_debug1_wb_rf_wdata;
    core_pkg::wen_t      o_debug0_wb_rf_wen, o_debug1_wb_rf_wen;
    core_pkg::reg_addr_t o_debug0_wb_rf_wnum, o_debug1_wb_rf_wnum;

    lane_t       lanes_a [$];
    lane_t       lanes_b [$];
    trace_t      exp_q [$]; // register writes in program order, lane a before lane b.
    logic [31:0] col [20];
    logic        loaded = 1'b0;
    int          limit_cycles;

    dual_issue_core dut0 (.*);

    always #50 clk = ~clk;

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
            stop_with_failure();
        end
    endtask

    function automatic lane_t lane_from_columns(input int base);
        lane_t l;
        l.valid  = col[base][0];
        l.pc     = col[base+1];
        l.op     = col[base+2][3:0];
        l.src1   = col[base+3][4:0];
        l.src2   = col[base+4][4:0];
        l.is_imm = col[base+5][0];
        l.imm    = col[base+6];
        l.dest   = col[base+7][4:0];
        return l;
    endfunction

    // lane b must wait one cycle when it reads the nonzero register that lane a writes.
    function automatic int pair_must_split(input lane_t a, input lane_t b);
        if (!a.valid || !b.valid || a.dest == 5'd0)
            return 0;
        if (b.src1 == a.dest || (!b.is_imm && b.src2 == a.dest))
            return 1;
        return 0;
    endfunction

    task automatic expect_trace(input int base);
        trace_t t;
        if (col[base][0] && col[base+8][4:0] != 5'd0) begin // a zero wnum means no trace.
            t.pc    = col[base+1];
            t.wnum  = col[base+8][4:0];
            t.wdata = col[base+9];
            exp_q.push_back(t);
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    n;
        string line;
        fd = $fopen("verification/core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/core_stimulus.txt");
            stop_with_failure();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16], col[17], col[18], col[19]);
            if (n != 20) begin
                $display("stimulus line has %0d fields instead of 20", n);
                stop_with_failure();
            end
            lanes_a.push_back(lane_from_columns(0));
            lanes_b.push_back(lane_from_columns(10));
            expect_trace(0);
            expect_trace(10);
        end
        $fclose(fd);
    endtask

    task automatic drive_pair(input lane_t a, input lane_t b);
        i_a_valid       <= a.valid;
        i_a_pc          <= a.pc;
        i_a_op          <= core_pkg::alu_op_t'(a.op);
        i_a_src1        <= a.src1;
        i_a_src2        <= a.src2;
        i_a_src2_is_imm <= a.is_imm;
        i_a_imm         <= a.imm;
        i_a_dest        <= a.dest;
        i_b_valid       <= b.valid;
        i_b_pc          <= b.pc;
        i_b_op          <= core_pkg::alu_op_t'(b.op);
        i_b_src1        <= b.src1;
        i_b_src2        <= b.src2;
        i_b_src2_is_imm <= b.is_imm;
        i_b_imm         <= b.imm;
        i_b_dest        <= b.dest;
    endtask

    task automatic drive_idle();
        i_a_valid <= 1'b0;
        i_b_valid <= 1'b0;
    endtask

    task automatic wait_accept(output int stalls);
        logic ready;
        ready = 1'b0;
        stalls = 0;
        while (!ready) begin
            @(negedge clk);
            ready = o_issue_ready; // settled half a cycle before the edge that uses it.
            if (!ready)
                stalls++;
            @(posedge clk);
        end
    endtask

    task automatic check_trace(input int port, input core_pkg::word_t pc,
                               input core_pkg::wen_t wen, input core_pkg::reg_addr_t wnum,
                               input core_pkg::word_t wdata);
        trace_t t;
        if (exp_q.size() == 0) begin
            $display("debug%0d reported a register write that the stimulus does not expect",
                     port);
            stop_with_failure();
        end
        t = exp_q.pop_front();
        check_value($sformatf("o_debug%0d_wb_rf_wen", port), 32'(wen), 32'hf);
        check_value($sformatf("o_debug%0d_wb_pc", port), pc, t.pc);
        check_value($sformatf("o_debug%0d_wb_rf_wnum", port), 32'(wnum), 32'(t.wnum));
        check_value($sformatf("o_debug%0d_wb_rf_wdata", port), wdata, t.wdata);
    endtask

    // lane a is older, so debug0 is taken first within a cycle.
    always @(negedge clk) begin
        if (!reset) begin
            if (o_debug0_wb_rf_wen != '0)
                check_trace(0, o_debug0_wb_pc, o_debug0_wb_rf_wen, o_debug0_wb_rf_wnum,
                            o_debug0_wb_rf_wdata);
            if (o_debug1_wb_rf_wen != '0)
                check_trace(1, o_debug1_wb_pc, o_debug1_wb_rf_wen, o_debug1_wb_rf_wnum,
                            o_debug1_wb_rf_wdata);
        end
    end

    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d clock cycles", limit_cycles);
        stop_with_failure();
    end

    initial begin
        int idle;
        int stalls;
        void'($urandom(46570));
        reset <= 1'b1;
        drive_pair('0, '0);
        read_stimulus();
        limit_cycles = lanes_a.size() * 4 + 50; // issue, split and two idle cycles per pair.
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("o_issue_ready", 32'(o_issue_ready), 32'h1);
        check_value("o_debug0_wb_rf_wen", 32'(o_debug0_wb_rf_wen), 32'h0);
        check_value("o_debug1_wb_rf_wen", 32'(o_debug1_wb_rf_wen), 32'h0);
        @(posedge clk);
        for (int i = 0; i < lanes_a.size(); i++) begin
            drive_pair(lanes_a[i], lanes_b[i]);
            wait_accept(stalls);
            check_value("o_issue_ready low cycles", 32'(stalls),
                        32'(pair_must_split(lanes_a[i], lanes_b[i])));
            idle = $urandom_range(2, 0);
            if (idle != 0) begin
                drive_idle();
                repeat (idle) @(posedge clk);
            end
        end
        drive_idle();
        repeat (12) @(posedge clk); // the last pair needs four edges to reach the trace.
        if (exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d expected register writes never appeared on the trace ports",
                     exp_q.size());
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: verification/core_stimulus.txt
# per lane, hex: valid pc op src1 src2 src2_is_imm imm dest exp_wnum exp_wdata; lane a, then lane b
# op: 0 add 1 sub 2 and 3 or 4 nor 5 xor 6 slt 7 sltu 8 sll 9 srl a sra; exp_wnum 0 means no trace
1 1000 0 00 00 1 12345678 01 01 12345678  1 1004 0 00 00 1 0000000f 02 02 0000000f
1 1008 0 00 00 1 f0f0f0f0 03 03 f0f0f0f0  1 100c 0 00 00 1 80000000 04 04 80000000
1 1010 0 00 00 1 ffffffff 05 05 ffffffff  1 1014 0 00 00 1 00000004 06 06 00000004
1 1018 0 01 02 0 00000000 07 07 12345687  1 101c 1 01 02 0 00000000 08 08 12345669
1 1020 2 01 03 0 00000000 09 09 10305070  1 1024 3 01 03 0 00000000 0a 0a f2f4f6f8
1 1028 4 01 03 0 00000000 0b 0b 0d0b0907  1 102c 5 01 03 0 00000000 0c 0c e2c4a688
1 1030 6 04 02 0 00000000 0d 0d 00000001  1 1034 7 04 02 0 00000000 0e 0e 00000000
1 1038 8 01 06 0 00000000 0f 0f 23456780  1 103c 9 04 06 0 00000000 10 10 08000000
1 1040 a 04 06 0 00000000 11 11 f8000000  1 1044 6 02 05 0 00000000 12 12 00000000
1 1048 7 02 05 0 00000000 13 13 00000001  1 104c a 01 00 1 00000024 14 14 01234567
1 1050 1 02 01 0 00000000 15 15 edcba997  1 1054 2 03 05 0 00000000 16 16 f0f0f0f0
1 1058 3 02 04 0 00000000 17 17 8000000f  1 105c 4 02 06 0 00000000 18 18 fffffff0
1 1060 5 05 01 0 00000000 19 19 edcba987  1 1064 6 05 02 0 00000000 1a 1a 00000001
1 1068 7 05 02 0 00000000 1b 1b 00000000  1 106c 8 05 00 1 0000001f 1c 1c 80000000
1 1070 9 05 00 1 0000001c 1d 1d 0000000f  1 1074 a 03 06 0 00000000 1e 1e ff0f0f0f
1 1078 0 00 00 1 00000100 01 01 00000100  1 107c 0 00 00 1 00000200 02 02 00000200
1 1080 0 01 02 0 00000000 03 03 00000300  1 1084 1 02 00 1 00000010 04 04 000001f0
1 1088 0 03 01 0 00000000 05 05 00000400  1 108c 5 04 02 0 00000000 06 06 000003f0
1 1090 0 05 02 0 00000000 07 07 00000600  1 1094 3 06 01 0 00000000 08 08 000003f0
1 1098 0 00 00 1 00000011 01 01 00000011  1 109c 0 07 08 0 00000000 09 09 000009f0
1 10a0 0 01 00 1 00000022 01 01 00000033  1 10a4 0 09 00 1 00000001 0a 0a 000009f1
1 10a8 0 01 00 0 00000000 0b 0b 00000033  1 10ac 2 0a 09 0 00000000 0c 0c 000009f0
1 10b0 0 00 00 1 00001000 0d 0d 00001000  1 10b4 0 0d 00 1 00000234 0e 0e 00001234
1 10b8 1 0e 0d 0 00000000 0f 0f 00000234  1 10bc 8 0f 00 1 00000004 10 10 00002340
1 10c0 5 10 0e 0 00000000 11 11 00003174  1 10c4 0 11 11 0 00000000 12 12 000062e8
1 10c8 0 01 00 1 00000055 00 00 00000000  1 10cc 0 00 00 0 00000000 13 13 00000000
1 10d0 3 00 00 0 00000000 14 14 00000000  1 10d4 0 00 00 1 00000077 00 00 00000000
1 10d8 0 00 00 1 00000005 15 15 00000005  1 10dc 4 00 00 0 00000000 16 16 ffffffff
1 10e0 0 00 00 1 0000aaaa 17 17 0000aaaa  1 10e4 0 00 00 1 0000bbbb 17 17 0000bbbb
1 10e8 0 17 00 0 00000000 18 18 0000bbbb  1 10ec 0 17 00 1 00000001 19 19 0000bbbc
1 10f0 0 00 00 1 00000001 1a 1a 00000001  1 10f4 0 00 00 1 00000002 1b 1b 00000002
1 10f8 0 00 00 1 00000003 1c 1c 00000003  1 10fc 0 00 00 1 00000004 1d 1d 00000004
1 1100 0 17 00 0 00000000 1e 1e 0000bbbb  1 1104 3 17 18 0 00000000 1f 1f 0000bbbb
1 1108 0 1f 00 1 00000010 01 01 0000bbcb  0 0000 0 00 00 0 00000000 00 00 00000000
0 0000 0 00 00 0 00000000 00 00 00000000  1 1114 1 01 1e 0 00000000 02 02 00000010

// File: files.f
+incdir+hdl
hdl/core_pkg.sv
hdl/regfile.sv
hdl/alu.sv
hdl/ro_stage.sv
hdl/ex_stage.sv
hdl/wb_stage.sv
hdl/dual_issue_core.sv
verification/core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the dual-issue core testbench with Verilator and runs it.
# The simulator exits nonzero on $fatal, which set -e turns into a failing status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module core_tb \
    -f files.f \
    -o core_sim

./obj_dir/core_sim
